// ==== files.f ====
source/common_pkg.sv
source/bram.sv
source/wb_arbiter.sv
source/fill_counter.sv
source/mem_init_fsm.sv
source/mem_subsys.sv
testbench/wb_driver.sv
testbench/mem_subsys_tb.sv

// ==== Makefile ====
TOP := mem_subsys_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test failures found" sim.log || ! grep -q "All tests passed!" sim.log; then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== testbench/mem_subsys_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_tb;

    localparam int          DEPTH   = 512;                  // ram size under test
    localparam logic [7:0]  FILL    = 8'hc3;                // clear value, not a power-on value
    localparam int          TIMEOUT = 2048;                 // cycles per wait
    localparam int          BURST   = 16;                   // strobes per pipelined run
    localparam logic [31:0] SEED    = 32'hd288cc0c;

    logic                                 clock;
    logic                                 reset_n;
    logic                                 clear;
    logic                                 busy;
    logic [common_pkg::WB_ADDR_WIDTH-1:0] wb_addr;
    logic [common_pkg::DATA_WIDTH-1:0]    wb_wdata;
    logic [common_pkg::DATA_WIDTH-1:0]    wb_rdata;
    logic                                 wb_we, wb_cycle, wb_strobe, wb_ack, wb_stall;

    logic [common_pkg::DATA_WIDTH-1:0]    model [DEPTH];    // shadow of the ram
    int                                   errors;

    mem_subsys #(.DATA_DEPTH(DEPTH), .FILL_BYTE(FILL)) DUT (
        .clock_i(clock), .reset_n_i(reset_n), .clear_i(clear), .busy_o(busy),
        .wb_addr_i(wb_addr), .wb_data_i(wb_wdata), .wb_data_o(wb_rdata),
        .wb_we_i(wb_we), .wb_cycle_i(wb_cycle), .wb_strobe_i(wb_strobe),
        .wb_ack_o(wb_ack), .wb_stall_o(wb_stall)
    );

    wb_driver #(.TIMEOUT(TIMEOUT), .MAX_BURST(BURST)) drv (
        .clock_i(clock), .reset_n_o(reset_n), .addr_o(wb_addr), .data_o(wb_wdata),
        .data_i(wb_rdata), .we_o(wb_we), .cycle_o(wb_cycle), .strobe_o(wb_strobe),
        .ack_i(wb_ack), .stall_i(wb_stall)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;                          // 4 ns period
    end

    // an idle engine leaves the port open on every cycle of the run
    always @(negedge clock) begin
        if (reset_n && !busy && wb_stall) begin
            $display("MISMATCH time=%0t signal=wb_stall_o expected=0 actual=1", $time);
            errors++;
        end
    end

    // ======================================================================
    // helpers
    // ======================================================================

    task automatic check_read(input logic [common_pkg::WB_ADDR_WIDTH-1:0] addr,
                              input logic [common_pkg::DATA_WIDTH-1:0] got);
        if (got !== model[addr]) begin
            $display("MISMATCH time=%0t signal=wb_data_o[%h] expected=%h actual=%h",
                     $time, addr, model[addr], got);
            errors++;
        end
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // wait for the clear to end while stall covers it throughout
    task automatic wait_idle(output int cycles);
        cycles = 0;
        while (busy && cycles < TIMEOUT) begin
            check_level("wb_stall_o", 1'b1, wb_stall);
            @(posedge clock);
            #1;
            cycles++;
        end
        if (busy) begin
            $display("timeout: busy_o still high after %0d cycles, engine in %s",
                     cycles, DUT.u_init.state_q.name());
            errors++;
        end
    endtask

    task automatic pulse_clear();
        clear = 1'b1;
        @(posedge clock);
        #1;
        clear = 1'b0;
    endtask

    task automatic fill_model_and_check_all();
        logic [common_pkg::DATA_WIDTH-1:0] rd;
        for (int i = 0; i < DEPTH; i++) model[i] = FILL;
        for (int i = 0; i < DEPTH; i++) begin
            drv.read_byte(common_pkg::WB_ADDR_WIDTH'(i), rd);
            check_read(common_pkg::WB_ADDR_WIDTH'(i), rd);
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================

    initial begin
        logic [common_pkg::WB_ADDR_WIDTH-1:0] addr_list [32];
        logic [common_pkg::WB_ADDR_WIDTH-1:0] a;
        logic [common_pkg::DATA_WIDTH-1:0]    d;
        logic [common_pkg::DATA_WIDTH-1:0]    rd;
        int                                   cycles;
        errors   = 0;
        clear    = 1'b0;
        void'($urandom(SEED));                              // one seed for the whole run

        drv.reset_bus(8);
        check_level("busy_o", 1'b1, busy);                  // clear starts out of reset
        check_level("wb_stall_o", 1'b1, wb_stall);
        wait_idle(cycles);
        for (int i = 0; i < DEPTH; i++) model[i] = FILL;
        for (int i = 0; i < 32; i++) begin
            a = common_pkg::WB_ADDR_WIDTH'($urandom_range(DEPTH - 1));
            drv.read_byte(a, rd);
            check_read(a, rd);
        end

        for (int i = 0; i < 32; i++) begin                  // write then read back
            addr_list[i] = common_pkg::WB_ADDR_WIDTH'($urandom_range(DEPTH - 1));
            d = common_pkg::DATA_WIDTH'($urandom);
            drv.write_byte(addr_list[i], d);
            model[addr_list[i]] = d;
        end
        for (int i = 0; i < 32; i++) begin
            drv.read_byte(addr_list[i], rd);
            check_read(addr_list[i], rd);
        end

        for (int j = 0; j < 8; j++) begin                   // mixed pipelined runs
            for (int i = 0; i < BURST; i++) begin
                drv.burst_we[i]    = 1'($urandom_range(1));
                drv.burst_addr[i]  = common_pkg::WB_ADDR_WIDTH'($urandom_range(DEPTH - 1));
                drv.burst_wdata[i] = common_pkg::DATA_WIDTH'($urandom);
            end
            drv.run_burst(BURST);
            for (int i = 0; i < BURST; i++) begin
                if (drv.burst_we[i]) model[drv.burst_addr[i]] = drv.burst_wdata[i];
                else check_read(drv.burst_addr[i], drv.burst_rdata[i]);
            end
        end

        pulse_clear();                                      // clear on request
        check_level("busy_o", 1'b1, busy);
        check_level("wb_stall_o", 1'b1, wb_stall);
        wait_idle(cycles);
        fill_model_and_check_all();

        for (int i = 0; i < 16; i++) begin                  // dirty the ram again
            a = common_pkg::WB_ADDR_WIDTH'($urandom_range(DEPTH - 1));
            drv.write_byte(a, common_pkg::DATA_WIDTH'($urandom));
        end
        pulse_clear();
        repeat (20) @(posedge clock);
        #1;
        check_level("busy_o", 1'b1, busy);
        pulse_clear();                                      // lands mid-clear and must be dropped
        wait_idle(cycles);
        if (cycles + 21 > DEPTH + 16) begin
            $display("clear with a second pulse kept busy_o high for %0d cycles", cycles + 21);
            errors++;
        end
        repeat (8) @(posedge clock);
        #1;
        check_level("busy_o", 1'b0, busy);                  // no second sweep queued
        fill_model_and_check_all();

        $display("summary: %0d testbench errors, %0d driver errors", errors, drv.errors);
        if (errors + drv.errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/wb_driver.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_driver #(
    parameter int TIMEOUT   = 2048,                         // cycles allowed per wait
    parameter int MAX_BURST = 16                            // deepest pipelined run
) (
    input  wire                                  clock_i,
    output logic                                 reset_n_o,
    output logic [common_pkg::WB_ADDR_WIDTH-1:0] addr_o,
    output logic [common_pkg::DATA_WIDTH-1:0]    data_o,
    input  wire  [common_pkg::DATA_WIDTH-1:0]    data_i,
    output logic                                 we_o,
    output logic                                 cycle_o,
    output logic                                 strobe_o,
    input  wire                                  ack_i,
    input  wire                                  stall_i
);

    logic                                 burst_we    [MAX_BURST];  // filled by the test
    logic [common_pkg::WB_ADDR_WIDTH-1:0] burst_addr  [MAX_BURST];
    logic [common_pkg::DATA_WIDTH-1:0]    burst_wdata [MAX_BURST];
    logic [common_pkg::DATA_WIDTH-1:0]    burst_rdata [MAX_BURST];  // captured on each ack
    int                                   errors;                   // timeouts and bad acks

    initial begin
        errors    = 0;
        reset_n_o = 1'b0;                                   // start in reset
        addr_o    = '0;
        data_o    = '0;
        we_o      = 1'b0;
        cycle_o   = 1'b0;
        strobe_o  = 1'b0;
    end

    // hold reset for a number of edges, release just after an edge
    task automatic reset_bus(input int cycles);
        reset_n_o = 1'b0;
        repeat (cycles) @(posedge clock_i);
        #1;
        reset_n_o = 1'b1;
    endtask

    // bus stays idle until the port is free, cycle low so the engine can take it
    task automatic wait_free(output logic ok);
        int n;
        n = 0;
        while (stall_i && n < TIMEOUT) begin
            @(posedge clock_i);
            #1;
            n++;
        end
        ok = !stall_i;
        if (!ok) begin
            $display("timeout: wb_stall_o stayed high for %0d cycles at %0t", n, $time);
            errors++;
        end
    endtask

    // ======================================================================
    // single transfers
    // ======================================================================

    task automatic access(input logic we, input logic [common_pkg::WB_ADDR_WIDTH-1:0] addr,
                          input logic [common_pkg::DATA_WIDTH-1:0] wdata,
                          output logic [common_pkg::DATA_WIDTH-1:0] rdata);
        int   n;
        logic ok;
        rdata = '0;
        wait_free(ok);
        if (!ok) return;
        cycle_o  = 1'b1;
        strobe_o = 1'b1;
        we_o     = we;
        addr_o   = addr;
        data_o   = wdata;
        @(posedge clock_i);                                 // accepted on this edge
        #1;
        strobe_o = 1'b0;
        n = 0;
        while (!ack_i && n < TIMEOUT) begin
            @(posedge clock_i);
            #1;
            n++;
        end
        if (!ack_i) begin
            $display("timeout: no wb_ack_o for address %h at %0t", addr, $time);
            errors++;
        end else begin
            rdata = data_i;                                 // valid while ack is high
        end
        cycle_o = 1'b0;
        we_o    = 1'b0;
    endtask

    task automatic write_byte(input logic [common_pkg::WB_ADDR_WIDTH-1:0] addr,
                              input logic [common_pkg::DATA_WIDTH-1:0] wdata);
        logic [common_pkg::DATA_WIDTH-1:0] unused;
        access(1'b1, addr, wdata, unused);
    endtask

    task automatic read_byte(input logic [common_pkg::WB_ADDR_WIDTH-1:0] addr,
                             output logic [common_pkg::DATA_WIDTH-1:0] rdata);
        access(1'b0, addr, '0, rdata);
    endtask

    // ======================================================================
    // pipelined run, one strobe per cycle
    // ======================================================================

    task automatic run_burst(input int count);
        logic ok;
        wait_free(ok);
        if (!ok) return;
        cycle_o = 1'b1;
        for (int i = 0; i <= count; i++) begin
            if (i < count) begin
                if (stall_i) begin
                    $display("MISMATCH time=%0t signal=wb_stall_o expected=0 actual=1", $time);
                    errors++;
                end
                strobe_o = 1'b1;
                we_o     = burst_we[i];
                addr_o   = burst_addr[i];
                data_o   = burst_wdata[i];
            end else begin
                strobe_o = 1'b0;                            // run over, one idle edge
                we_o     = 1'b0;
            end
            @(posedge clock_i);
            #1;
            if (ack_i !== (i < count)) begin                // one ack per strobe, no extras
                $display("MISMATCH time=%0t signal=wb_ack_o expected=%b actual=%b",
                         $time, (i < count), ack_i);
                errors++;
            end
            if (i < count) burst_rdata[i] = data_i;
        end
        cycle_o = 1'b0;
    endtask

endmodule

`default_nettype wire

// ==== source/mem_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsys #(
    parameter int                                DATA_DEPTH = 512,   // ram size in bytes
    parameter logic [common_pkg::DATA_WIDTH-1:0] FILL_BYTE  = 8'h00  // value written by a clear
) (
    input  wire                                  clock_i,
    input  wire                                  reset_n_i,
    input  wire                                  clear_i,
    output logic                                 busy_o,
    input  wire  [common_pkg::WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  wire  [common_pkg::DATA_WIDTH-1:0]    wb_data_i,
    output logic [common_pkg::DATA_WIDTH-1:0]    wb_data_o,
    input  wire                                  wb_we_i,
    input  wire                                  wb_cycle_i,
    input  wire                                  wb_strobe_i,
    output logic                                 wb_ack_o,
    output logic                                 wb_stall_o
);

    // engine to arbiter
    logic                                 init_req, init_gnt, init_we, init_strobe, init_ack;
    logic [common_pkg::WB_ADDR_WIDTH-1:0] init_addr;
    logic [common_pkg::DATA_WIDTH-1:0]    init_data;
    // arbiter to ram
    logic                                 mem_we, mem_cycle, mem_strobe, mem_ack, mem_stall;
    logic [common_pkg::WB_ADDR_WIDTH-1:0] mem_addr;
    logic [common_pkg::DATA_WIDTH-1:0]    mem_wdata, mem_rdata;
    // engine to counter
    logic                                 cnt_clear, cnt_advance, cnt_last;
    logic [common_pkg::WB_ADDR_WIDTH-1:0] cnt_addr;

    mem_init_fsm #(.DATA_DEPTH(DATA_DEPTH), .FILL_BYTE(FILL_BYTE)) u_init (
        .clock_i(clock_i), .reset_n_i(reset_n_i), .clear_i(clear_i), .busy_o(busy_o),
        .req_o(init_req), .gnt_i(init_gnt), .addr_o(init_addr), .data_o(init_data),
        .we_o(init_we), .strobe_o(init_strobe), .ack_i(init_ack),
        .cnt_clear_o(cnt_clear), .cnt_advance_o(cnt_advance),
        .cnt_addr_i(cnt_addr), .cnt_last_i(cnt_last)
    );

    fill_counter #(.DATA_DEPTH(DATA_DEPTH)) u_counter (
        .clock_i(clock_i), .reset_n_i(reset_n_i), .clear_i(cnt_clear),
        .advance_i(cnt_advance), .addr_o(cnt_addr), .last_o(cnt_last)
    );

    wb_arbiter u_arbiter (
        .clock_i(clock_i), .reset_n_i(reset_n_i),
        .ext_addr_i(wb_addr_i), .ext_data_i(wb_data_i), .ext_data_o(wb_data_o),
        .ext_we_i(wb_we_i), .ext_cycle_i(wb_cycle_i), .ext_strobe_i(wb_strobe_i),
        .ext_ack_o(wb_ack_o), .ext_stall_o(wb_stall_o),
        .init_req_i(init_req), .init_gnt_o(init_gnt), .init_addr_i(init_addr),
        .init_data_i(init_data), .init_we_i(init_we), .init_strobe_i(init_strobe),
        .init_ack_o(init_ack),
        .mem_addr_o(mem_addr), .mem_data_o(mem_wdata), .mem_data_i(mem_rdata),
        .mem_we_o(mem_we), .mem_cycle_o(mem_cycle), .mem_strobe_o(mem_strobe),
        .mem_ack_i(mem_ack), .mem_stall_i(mem_stall)
    );

    bram #(.DATA_DEPTH(DATA_DEPTH)) u_bram (
        .clock_i(clock_i), .reset_n_i(reset_n_i), .wb_addr_i(mem_addr),
        .wb_data_i(mem_wdata), .wb_data_o(mem_rdata), .wb_we_i(mem_we),
        .wb_cycle_i(mem_cycle), .wb_strobe_i(mem_strobe),
        .wb_ack_o(mem_ack), .wb_stall_o(mem_stall)
    );

endmodule

`default_nettype wire

// ==== source/mem_init_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_init_fsm #(
    parameter int                                DATA_DEPTH = 512,   // locations to clear
    parameter logic [common_pkg::DATA_WIDTH-1:0] FILL_BYTE  = 8'h00  // clear value
) (
    input  wire                                  clock_i,
    input  wire                                  reset_n_i,
    input  wire                                  clear_i,
    output logic                                 busy_o,
    // bus request side
    output logic                                 req_o,
    input  wire                                  gnt_i,
    output logic [common_pkg::WB_ADDR_WIDTH-1:0] addr_o,
    output logic [common_pkg::DATA_WIDTH-1:0]    data_o,
    output logic                                 we_o,
    output logic                                 strobe_o,
    input  wire                                  ack_i,
    // address counter
    output logic                                 cnt_clear_o,
    output logic                                 cnt_advance_o,
    input  wire  [common_pkg::WB_ADDR_WIDTH-1:0] cnt_addr_i,
    input  wire                                  cnt_last_i
);

    common_pkg::fill_state_t state_q;                       // engine state
    logic [1:0]              pending_q;                     // writes awaiting ack
    logic                    drained;                       // nothing left in flight

    if (DATA_DEPTH < 2 || DATA_DEPTH > (1 << common_pkg::WB_ADDR_WIDTH)) begin : g_depth
        $error("DATA_DEPTH does not fit the bus address");
    end

    // ======================================================================
    // state register
    // ======================================================================

    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            state_q <= common_pkg::REQUEST;                 // clear runs straight out of reset
        end else begin
            case (state_q)
                common_pkg::IDLE:    if (clear_i) state_q <= common_pkg::REQUEST;
                common_pkg::REQUEST: if (gnt_i) state_q <= common_pkg::WRITE;
                common_pkg::WRITE:   if (cnt_last_i) state_q <= common_pkg::DRAIN;
                common_pkg::DRAIN:   if (drained) state_q <= common_pkg::IDLE;
                default:             state_q <= common_pkg::IDLE;
            endcase
        end
    end

    // writes in flight stay at 0 or 1 with a one cycle ack
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            pending_q <= 2'd0;
        end else if (strobe_o && !ack_i) begin
            pending_q <= pending_q + 2'd1;
        end else if (!strobe_o && ack_i) begin
            pending_q <= pending_q - 2'd1;
        end
    end

    assign drained = (pending_q == 2'd0) | ((pending_q == 2'd1) & ack_i);

    // ======================================================================
    // outputs
    // ======================================================================

    assign busy_o        = (state_q != common_pkg::IDLE);   // clear_i ignored while high
    assign req_o         = busy_o;                          // hold the port through drain
    assign strobe_o      = (state_q == common_pkg::WRITE);  // back-to-back fill writes
    assign we_o          = strobe_o;
    assign addr_o        = cnt_addr_i;
    assign data_o        = FILL_BYTE;
    assign cnt_clear_o   = (state_q == common_pkg::REQUEST);
    assign cnt_advance_o = strobe_o & ~cnt_last_i;          // park on the last address

    // fill writes only go out on a granted port
    assert property (@(posedge clock_i) disable iff (!reset_n_i)
        strobe_o |-> gnt_i)
        else $error("fill strobe without grant");

endmodule

`default_nettype wire

// ==== source/fill_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module fill_counter #(
    parameter int DATA_DEPTH = 512                          // locations to sweep
) (
    input  wire                                  clock_i,
    input  wire                                  reset_n_i,
    input  wire                                  clear_i,
    input  wire                                  advance_i,
    output logic [common_pkg::WB_ADDR_WIDTH-1:0] addr_o,
    output logic                                 last_o
);

    localparam logic [common_pkg::WB_ADDR_WIDTH-1:0] LAST_ADDR =
        common_pkg::WB_ADDR_WIDTH'(DATA_DEPTH - 1);        // final ram location

    // address register, clear wins over advance
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            addr_o <= '0;
        end else if (clear_i) begin
            addr_o <= '0;                                   // restart the sweep
        end else if (advance_i) begin
            addr_o <= addr_o + 1'b1;
        end
    end

    assign last_o = (addr_o == LAST_ADDR);                  // sweep ends here

    // the engine must stop stepping at the last location
    assert property (@(posedge clock_i) disable iff (!reset_n_i)
        advance_i |-> !last_o)
        else $error("fill counter advanced past the last location");

endmodule

`default_nettype wire

// ==== source/wb_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_arbiter (
    input  wire                                  clock_i,
    input  wire                                  reset_n_i,
    // external master
    input  wire  [common_pkg::WB_ADDR_WIDTH-1:0] ext_addr_i,
    input  wire  [common_pkg::DATA_WIDTH-1:0]    ext_data_i,
    output logic [common_pkg::DATA_WIDTH-1:0]    ext_data_o,
    input  wire                                  ext_we_i,
    input  wire                                  ext_cycle_i,
    input  wire                                  ext_strobe_i,
    output logic                                 ext_ack_o,
    output logic                                 ext_stall_o,
    // clear engine
    input  wire                                  init_req_i,
    output logic                                 init_gnt_o,
    input  wire  [common_pkg::WB_ADDR_WIDTH-1:0] init_addr_i,
    input  wire  [common_pkg::DATA_WIDTH-1:0]    init_data_i,
    input  wire                                  init_we_i,
    input  wire                                  init_strobe_i,
    output logic                                 init_ack_o,
    // ram port
    output logic [common_pkg::WB_ADDR_WIDTH-1:0] mem_addr_o,
    output logic [common_pkg::DATA_WIDTH-1:0]    mem_data_o,
    input  wire  [common_pkg::DATA_WIDTH-1:0]    mem_data_i,
    output logic                                 mem_we_o,
    output logic                                 mem_cycle_o,
    output logic                                 mem_strobe_o,
    input  wire                                  mem_ack_i,
    input  wire                                  mem_stall_i
);

    logic owner_q;                                          // engine holds the ram port

    // take the port only between external cycles and keep it while req stays up
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            owner_q <= 1'b0;
        end else begin
            owner_q <= init_req_i & (owner_q | ~ext_cycle_i);
        end
    end

    assign init_gnt_o  = owner_q & init_req_i;              // drops in the same cycle as req
    assign ext_stall_o = init_req_i | mem_stall_i;          // held off for the whole clear

    // request mux
    assign mem_addr_o   = init_gnt_o ? init_addr_i   : ext_addr_i;
    assign mem_data_o   = init_gnt_o ? init_data_i   : ext_data_i;
    assign mem_we_o     = init_gnt_o ? init_we_i     : ext_we_i;
    assign mem_cycle_o  = init_gnt_o | ext_cycle_i;         // engine cycle spans the grant
    assign mem_strobe_o = init_gnt_o ? init_strobe_i : (ext_strobe_i & ~ext_stall_o);

    // response steering
    assign ext_data_o = mem_data_i;                         // engine never reads
    assign ext_ack_o  = mem_ack_i & ~init_gnt_o;
    assign init_ack_o = mem_ack_i & init_gnt_o;

    // an ack always returns to the master that issued its strobe
    assert property (@(posedge clock_i) disable iff (!reset_n_i)
        mem_ack_i |-> $stable(init_gnt_o))
        else $error("grant moved between a strobe and its ack");

    // engine releases only once its acks are home
    assert property (@(posedge clock_i) disable iff (!reset_n_i)
        $fell(init_gnt_o) |-> !mem_ack_i)
        else $error("grant dropped with an ack in flight");

endmodule

`default_nettype wire

// ==== source/bram.sv ====
`timescale 1ns/10ps
`default_nettype none

module bram #(
    parameter int DATA_DEPTH = 512                          // number of byte locations
) (
    input  wire                                  clock_i,
    input  wire                                  reset_n_i,
    input  wire  [common_pkg::WB_ADDR_WIDTH-1:0] wb_addr_i,
    input  wire  [common_pkg::DATA_WIDTH-1:0]    wb_data_i,
    output logic [common_pkg::DATA_WIDTH-1:0]    wb_data_o,
    input  wire                                  wb_we_i,
    input  wire                                  wb_cycle_i,
    input  wire                                  wb_strobe_i,
    output logic                                 wb_ack_o,
    output logic                                 wb_stall_o
);

    localparam int ADDR_BITS = $clog2(DATA_DEPTH);         // bits that index the array

    logic [common_pkg::DATA_WIDTH-1:0] mem [DATA_DEPTH];   // byte storage
    logic                              accept;             // transfer taken this cycle

    assign wb_stall_o = 1'b0;                               // single cycle ram that never stalls
    assign accept     = wb_cycle_i & wb_strobe_i & ~wb_stall_o;

    // storage and registered read data
    always_ff @(posedge clock_i) begin
        if (accept) begin
            if (wb_we_i) begin
                mem[wb_addr_i[ADDR_BITS-1:0]] <= wb_data_i;    // upper address bits alias
            end else begin
                wb_data_o <= mem[wb_addr_i[ADDR_BITS-1:0]];    // valid while ack is high
            end
        end
    end

    // ack follows acceptance by one cycle
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= accept;
        end
    end

    // a strobe is only legal inside a bus cycle
    assert property (@(posedge clock_i) disable iff (!reset_n_i)
        wb_strobe_i |-> wb_cycle_i)
        else $error("bram strobe outside a bus cycle");

endmodule

`default_nettype wire

// ==== source/common_pkg.sv ====
`default_nettype none

// ======================================================================
// shared bus widths and fill engine encoding
// ======================================================================

package common_pkg;

    localparam int DATA_WIDTH    = 8;                       // one bus byte
    localparam int WB_ADDR_WIDTH = 10;                      // bus address width

    // states of the ram clear engine
    typedef enum logic [1:0] {
        IDLE    = 2'd0,                                     // bus released, waiting for clear
        REQUEST = 2'd1,                                     // asking the arbiter for the ram port
        WRITE   = 2'd2,                                     // one fill byte per cycle
        DRAIN   = 2'd3                                      // waiting for the last acks
    } fill_state_t;

endpackage

`default_nettype wire
